// File: tb.f
+incdir+src
src/rob_except_pkg.sv
src/rob_entry_pkg.sv
src/rob_alloc_if.sv
src/rob_head_if.sv
src/rob_dispatch_intake.sv
src/rob_entry_array.sv
src/rob_commit_select.sv
src/rob_top.sv
verification/rob_clk_gen.sv
verification/rob_tb.sv

// File: verification/rob_tb.sv
`timescale 1ns/10ps
`include "rob_settings.svh"

module rob_tb
  import rob_entry_pkg::*;
  import rob_except_pkg::*;
();

  localparam int NUM_TESTS   = 4;
  localparam int TEST_CYCLES = 80;
  localparam int WATCHDOG    = NUM_TESTS * 200 + 20;
  localparam except_t CAUSES [7] = '{inst_addr_misalign, inst_acc_fault, illegal_inst,
                                     breakpoint, load_acc_fault, store_acc_fault, ecall_m};

  // DUT ports carry the port names of rob_top
  logic                                      i_clk, i_reset_n, i_disp_valid, i_done_valid;
  logic                                      i_done_except_valid, o_commit_valid;
  grp_mask_t                                 i_disp_grp_id, i_disp_except_valid, i_done_lane;
  grp_mask_t                                 o_commit_grp_id, o_commit_dead_id;
  grp_mask_t                                 o_commit_except_valid;
  logic [`ROB_PC_W-1:0]                      i_disp_pc, o_commit_epc;
  logic [`ROB_DISP_SIZE-1:0][`ROB_EXC_W-1:0] i_disp_except_type;
  logic [`ROB_EXC_W-1:0]                     i_done_except_type, o_commit_except_type;
  cmt_id_t                                   o_new_cmt_id, i_done_cmt_id, o_commit_cmt_id;
  logic [1:0]                                o_credit_return_val;

  // ----------------------------------------
  // reference model of the groups in flight
  // ----------------------------------------

  grp_mask_t                                 m_grp [`ROB_ENTRY_SIZE];
  grp_mask_t                                 m_pend [`ROB_ENTRY_SIZE];
  grp_mask_t                                 m_exc [`ROB_ENTRY_SIZE];
  logic [`ROB_DISP_SIZE-1:0][`ROB_EXC_W-1:0] m_type [`ROB_ENTRY_SIZE];
  logic [`ROB_PC_W-1:0]                      m_pc [`ROB_ENTRY_SIZE];
  logic [`ROB_ENTRY_SIZE-1:0]                m_dead = '0;
  cmt_id_t                                   m_head = '0;
  cmt_id_t                                   m_tail = '0;
  entry_idx_t                                hi;
  int                                        m_count = 0, disp_total = 0, ret_total = 0;
  int                                        credits = `ROB_ENTRY_SIZE;
  int                                        errors = 0;
  integer                                    seed = 32'h4a830a4e;

  logic                                      exp_valid;
  grp_mask_t                                 exp_dead, exp_exc;
  logic [`ROB_EXC_W-1:0]                     exp_type;
  logic [`ROB_PC_W-1:0]                      exp_epc;
  logic [1:0]                                exp_credit;

  rob_clk_gen rob_clk_gen_inst (.o_clk(i_clk), .o_reset_n(i_reset_n));

  rob_top rob_top_inst (.*);

  task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] %0d ns: %s", $time, msg);
  endtask

  assign hi = m_head[ENTRY_W-1:0];

  // oldest excepting lane wins, so the scan runs from the top lane down
  always_comb begin
    exp_valid = (m_count != 0) && (m_dead[hi] || (m_pend[hi] == '0));
    exp_exc   = '0;
    exp_type  = '0;
    exp_epc   = m_pc[hi];
    exp_dead  = m_dead[hi] ? m_grp[hi] : '0;
    for (int d = `ROB_DISP_SIZE - 1; d >= 0; d--) begin
      if (!m_dead[hi] && m_exc[hi][d]) begin
        exp_exc  = grp_mask_t'(1 << d);
        exp_type = m_type[hi][d];
        exp_epc  = m_pc[hi] + `ROB_PC_W'(4 * d);
        exp_dead = m_grp[hi] & ~grp_mask_t'((2 << d) - 1);
      end
    end
    // one credit per commit and one per dispatch dropped by a flush
    exp_credit = 2'(exp_valid) + 2'(i_disp_valid && exp_valid && (exp_exc != '0));
  end

  // ----------------------------------------
  // checks against the model
  // ----------------------------------------

  a_commit_when: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_commit_valid == exp_valid)
    else report_error($sformatf("commit valid %b, model expects %b",
                                $sampled(o_commit_valid), $sampled(exp_valid)));

  a_commit_order: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    exp_valid |-> (o_commit_cmt_id == m_head) && (o_commit_grp_id == m_grp[hi]) &&
                  (o_commit_dead_id == exp_dead))
    else report_error($sformatf("commit of id %0d has wrong id, group or dead mask",
                                $sampled(m_head)));

  a_commit_exc: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    exp_valid |-> (o_commit_except_valid == exp_exc) && ((exp_exc == '0) ||
                  ((o_commit_except_type == exp_type) && (o_commit_epc == exp_epc))))
    else report_error($sformatf("commit of id %0d has wrong exception lane, type or epc",
                                $sampled(m_head)));

  a_alloc_id: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_new_cmt_id == m_tail)
    else report_error($sformatf("new cmt id %0d, model expects %0d",
                                $sampled(o_new_cmt_id), $sampled(m_tail)));

  a_credit_now: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_credit_return_val == exp_credit)
    else report_error($sformatf("credit return %0d, model expects %0d",
                                $sampled(o_credit_return_val), $sampled(exp_credit)));

  // the model applies the commit before the inputs of this cycle
  always @(posedge i_clk) begin
    logic       flush;
    entry_idx_t t;
    flush = exp_valid && (exp_exc != '0);
    if (i_reset_n) begin
      ret_total = ret_total + o_credit_return_val;
      credits   = credits + exp_credit;
      if (exp_valid) begin
        m_head  = m_head + 1'b1;
        m_count = m_count - 1;
      end
      // a committed exception kills every younger group
      if (flush) begin
        for (int k = 0; k < m_count; k++) begin
          m_dead[m_head[ENTRY_W-1:0] + entry_idx_t'(k)] = 1'b1;
        end
      end
      if (i_disp_valid) begin
        credits    = credits - 1;
        disp_total = disp_total + 1;
      end
      if (i_disp_valid && !flush) begin
        t         = m_tail[ENTRY_W-1:0];
        m_grp[t]  = i_disp_grp_id;
        m_pend[t] = i_disp_grp_id & ~i_disp_except_valid;
        m_exc[t]  = i_disp_except_valid;
        m_type[t] = i_disp_except_type;
        m_pc[t]   = i_disp_pc;
        m_dead[t] = 1'b0;
        m_tail    = m_tail + 1'b1;
        m_count   = m_count + 1;
      end
      if (i_done_valid) begin
        t         = i_done_cmt_id[ENTRY_W-1:0];
        m_pend[t] = m_pend[t] & ~i_done_lane;
        for (int d = 0; d < `ROB_DISP_SIZE; d++) begin
          if (i_done_except_valid && i_done_lane[d]) begin
            m_exc[t][d]  = 1'b1;
            m_type[t][d] = i_done_except_type;
          end
        end
      end
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  // higher phase numbers raise the exception rate
  task automatic drive_cycle(input int phase, input bit allow_disp);
    grp_mask_t  g;
    entry_idx_t off;
    entry_idx_t idx;
    int         lane;
    int         l;
    @(negedge i_clk);
    i_disp_valid = 1'b0;
    i_done_valid = 1'b0;
    if (allow_disp && (credits > 0) && (($random(seed) & 3) != 0)) begin
      g                   = grp_mask_t'($random(seed));
      i_disp_valid        = 1'b1;
      i_disp_grp_id       = (g == '0) ? grp_mask_t'(1) : g;
      i_disp_pc           = $random(seed);
      i_disp_except_valid = (($random(seed) & 7) < phase) ?
                            (i_disp_grp_id & grp_mask_t'($random(seed))) : '0;
      for (int d = 0; d < `ROB_DISP_SIZE; d++) begin
        i_disp_except_type[d] = CAUSES[$unsigned($random(seed)) % 7];
      end
    end
    // one report for a random pending lane of a live group
    if ((m_count != 0) && (($random(seed) & 3) != 0)) begin
      off  = entry_idx_t'($unsigned($random(seed)) % m_count);
      idx  = m_head[ENTRY_W-1:0] + off;
      lane = $unsigned($random(seed)) % `ROB_DISP_SIZE;
      for (int j = 0; j < `ROB_DISP_SIZE; j++) begin
        l = (lane + j) % `ROB_DISP_SIZE;
        if (!i_done_valid && !m_dead[idx] && m_pend[idx][l]) begin
          i_done_valid        = 1'b1;
          i_done_cmt_id       = m_head + cmt_id_t'(off);
          i_done_lane         = grp_mask_t'(1 << l);
          i_done_except_valid = (($random(seed) & 15) < phase);
          i_done_except_type  = CAUSES[$unsigned($random(seed)) % 7];
        end
      end
    end
  endtask

  initial begin
    {i_disp_valid, i_disp_grp_id, i_disp_pc, i_disp_except_valid, i_disp_except_type,
     i_done_valid, i_done_cmt_id, i_done_lane, i_done_except_valid, i_done_except_type} = '0;
    wait (i_reset_n === 1'b1);
    for (int p = 0; p < NUM_TESTS; p++) begin
      repeat (TEST_CYCLES) drive_cycle(p, 1'b1);
      // drain before the next phase
      while (m_count != 0) drive_cycle(p, 1'b0);
    end
    a_credit_sum: assert (ret_total == disp_total)
      else report_error($sformatf("%0d credits returned for %0d dispatches",
                                  ret_total, disp_total));
    $display("%0d dispatches, %0d errors", disp_total, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG) @(posedge i_clk);
    $display("timeout after %0d cycles, the ROB stopped committing", WATCHDOG);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: verification/rob_clk_gen.sv
`timescale 1ns/10ps

module rob_clk_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 4
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  // release on a falling edge, away from the flops
  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

// File: src/rob_top.sv
`timescale 1ns/10ps
`include "rob_settings.svh"

module rob_top
  import rob_except_pkg::*;
(
  input  logic                                      i_clk,
  input  logic                                      i_reset_n,

  // dispatch group
  input  logic                                      i_disp_valid,
  input  logic [`ROB_DISP_SIZE-1:0]                 i_disp_grp_id,
  input  logic [`ROB_PC_W-1:0]                      i_disp_pc,
  input  logic [`ROB_DISP_SIZE-1:0]                 i_disp_except_valid,
  input  logic [`ROB_DISP_SIZE-1:0][`ROB_EXC_W-1:0] i_disp_except_type,
  output logic [$clog2(`ROB_ENTRY_SIZE):0]          o_new_cmt_id,
  output logic [1:0]                                o_credit_return_val,

  // done report
  input  logic                                      i_done_valid,
  input  logic [$clog2(`ROB_ENTRY_SIZE):0]          i_done_cmt_id,
  input  logic [`ROB_DISP_SIZE-1:0]                 i_done_lane,
  input  logic                                      i_done_except_valid,
  input  logic [`ROB_EXC_W-1:0]                     i_done_except_type,

  // commit
  output logic                                      o_commit_valid,
  output logic [$clog2(`ROB_ENTRY_SIZE):0]          o_commit_cmt_id,
  output logic [`ROB_DISP_SIZE-1:0]                 o_commit_grp_id,
  output logic [`ROB_DISP_SIZE-1:0]                 o_commit_dead_id,
  output logic [`ROB_DISP_SIZE-1:0]                 o_commit_except_valid,
  output logic [`ROB_EXC_W-1:0]                     o_commit_except_type,
  output logic [`ROB_PC_W-1:0]                      o_commit_epc
);

  except_t [`ROB_DISP_SIZE-1:0] w_disp_except_type;
  except_t                      w_done_except_type;
  except_t                      w_commit_except_type;
  logic                         w_commit;
  logic                         w_flush;

  rob_alloc_if alloc_if ();
  rob_head_if  head_if ();

  // raw cause codes into the enum
  for (genvar d = 0; d < `ROB_DISP_SIZE; d++) begin : g_disp_cause
    assign w_disp_except_type[d] = except_t'(i_disp_except_type[d]);
  end

  assign w_done_except_type   = except_t'(i_done_except_type);
  assign o_commit_except_type = w_commit_except_type;

  rob_dispatch_intake rob_dispatch_intake_inst (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_disp_valid        (i_disp_valid),
    .i_disp_grp_id       (i_disp_grp_id),
    .i_disp_pc           (i_disp_pc),
    .i_disp_except_valid (i_disp_except_valid),
    .i_disp_except_type  (w_disp_except_type),
    .i_commit            (w_commit),
    .i_flush             (w_flush),
    .o_new_cmt_id        (o_new_cmt_id),
    .o_credit_return_val (o_credit_return_val),
    .alloc               (alloc_if.source)
  );

  rob_entry_array rob_entry_array_inst (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_done_valid        (i_done_valid),
    .i_done_cmt_id       (i_done_cmt_id),
    .i_done_lane         (i_done_lane),
    .i_done_except_valid (i_done_except_valid),
    .i_done_except_type  (w_done_except_type),
    .alloc               (alloc_if.sink),
    .head                (head_if.array)
  );

  rob_commit_select rob_commit_select_inst (
    .i_clk                 (i_clk),
    .i_reset_n             (i_reset_n),
    .head                  (head_if.selector),
    .o_commit_valid        (o_commit_valid),
    .o_commit_cmt_id       (o_commit_cmt_id),
    .o_commit_grp_id       (o_commit_grp_id),
    .o_commit_dead_id      (o_commit_dead_id),
    .o_commit_except_valid (o_commit_except_valid),
    .o_commit_except_type  (w_commit_except_type),
    .o_commit_epc          (o_commit_epc),
    .o_commit              (w_commit),
    .o_flush               (w_flush)
  );

endmodule

// File: src/rob_commit_select.sv
`timescale 1ns/10ps
`include "rob_settings.svh"

module rob_commit_select
  import rob_entry_pkg::*;
  import rob_except_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  rob_head_if.selector         head,

  output logic                 o_commit_valid,
  output cmt_id_t              o_commit_cmt_id,
  output grp_mask_t            o_commit_grp_id,
  output grp_mask_t            o_commit_dead_id,
  output grp_mask_t            o_commit_except_valid,
  output except_t              o_commit_except_type,
  output logic [`ROB_PC_W-1:0] o_commit_epc,

  // toward the dispatch intake
  output logic                 o_commit,
  output logic                 o_flush
);

  localparam int LANE_W = $clog2(`ROB_DISP_SIZE);

  cmt_id_t           r_head_id;
  commit_state_t     r_state;
  rob_entry_t        w_head;
  logic              w_all_done;
  logic              w_killing;
  logic              w_commit;
  grp_mask_t         w_exc_cand;
  grp_mask_t         w_exc_oh;
  grp_mask_t         w_exc_valid;
  grp_mask_t         w_dead_above;
  logic [LANE_W-1:0] w_exc_lane;
  except_t           w_exc_type;

  assign head.head_idx = r_head_id[ENTRY_W-1:0];
  assign w_head        = head.head_entry;

  // ----------------------------------------
  // commit condition
  // ----------------------------------------

  assign w_all_done = w_head.valid & (w_head.done_grp_id == w_head.grp_id);

  // dead groups leave without waiting for their lanes
  assign w_killing  = (r_state == commit_killing) & w_head.valid &
                      (w_head.dead == w_head.grp_id);
  assign w_commit   = w_all_done | w_killing;

  // ----------------------------------------
  // exception pick
  // ----------------------------------------

  // oldest excepting lane is the lowest one
  assign w_exc_cand   = w_killing ? '0 : (w_head.except_valid & w_head.grp_id);
  assign w_exc_oh     = w_exc_cand & (~w_exc_cand + 1'b1);
  assign w_exc_valid  = w_commit ? w_exc_oh : '0;

  // lanes younger than the pick
  assign w_dead_above = ~(w_exc_oh | (w_exc_oh - 1'b1));

  always_comb begin
    w_exc_lane = '0;
    w_exc_type = inst_addr_misalign;
    for (int d = 0; d < `ROB_DISP_SIZE; d++) begin
      if (w_exc_oh[d]) begin
        w_exc_lane = LANE_W'(d);
        w_exc_type = w_head.except_type[d];
      end
    end
  end

  assign o_commit_valid        = w_commit;
  assign o_commit_cmt_id       = r_head_id;
  assign o_commit_grp_id       = w_head.grp_id;
  assign o_commit_dead_id      = (w_dead_above | w_head.dead) & w_head.grp_id;
  assign o_commit_except_valid = w_exc_valid;
  assign o_commit_except_type  = w_exc_type;
  // four bytes per lane
  assign o_commit_epc          = w_head.pc + `ROB_PC_W'({w_exc_lane, 2'b00});

  assign o_commit           = w_commit;
  assign o_flush            = |w_exc_valid;
  assign head.commit_finish = w_commit;
  assign head.kill          = o_flush;
  assign head.state         = r_state;

  // ----------------------------------------
  // head pointer and state
  // ----------------------------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head_id <= '0;
    end else if (w_commit) begin
      r_head_id <= r_head_id + 1'b1;
    end
  end

  // back to normal once the head holds no dead group
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= commit_normal;
    end else if (o_flush) begin
      r_state <= commit_killing;
    end else if (!w_killing) begin
      r_state <= commit_normal;
    end
  end

  // a group committing outside the drain of a flush was never killed
  ap_commit_head: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    w_commit |-> ((w_head.done_grp_id & ~w_head.grp_id) == '0) &&
      ((r_state == commit_killing) || (w_head.dead == '0))
  );

endmodule

// File: src/rob_entry_array.sv
`timescale 1ns/10ps
`include "rob_settings.svh"

module rob_entry_array
  import rob_entry_pkg::*;
  import rob_except_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,

  // execution done report, one lane per cycle
  input  logic      i_done_valid,
  input  cmt_id_t   i_done_cmt_id,
  input  grp_mask_t i_done_lane,
  input  logic      i_done_except_valid,
  input  except_t   i_done_except_type,

  rob_alloc_if.sink alloc,
  rob_head_if.array head
);

  rob_entry_t                 r_entries [`ROB_ENTRY_SIZE];
  logic [`ROB_ENTRY_SIZE-1:0] r_valid;
  entry_idx_t                 w_done_idx;
  logic [`ROB_ENTRY_SIZE-1:0] w_load_hit;
  logic [`ROB_ENTRY_SIZE-1:0] w_done_hit;
  logic [`ROB_ENTRY_SIZE-1:0] w_finish_hit;

  assign w_done_idx = i_done_cmt_id[ENTRY_W-1:0];

  // ----------------------------------------
  // per-entry selects
  // ----------------------------------------

  always_comb begin
    for (int i = 0; i < `ROB_ENTRY_SIZE; i++) begin
      w_load_hit[i]   = alloc.load_valid & (alloc.load_idx == entry_idx_t'(i));
      w_finish_hit[i] = head.commit_finish & (head.head_idx == entry_idx_t'(i));
      // reports for killed groups are dropped
      w_done_hit[i]   = i_done_valid & (w_done_idx == entry_idx_t'(i)) &
                        r_valid[i] & (r_entries[i].dead == '0);
    end
  end

  // valid flags
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else begin
      for (int i = 0; i < `ROB_ENTRY_SIZE; i++) begin
        if (w_load_hit[i]) begin
          r_valid[i] <= 1'b1;
        end else if (w_finish_hit[i]) begin
          r_valid[i] <= 1'b0;
        end
      end
    end
  end

  // ----------------------------------------
  // record contents
  // ----------------------------------------

  always_ff @(posedge i_clk) begin
    for (int i = 0; i < `ROB_ENTRY_SIZE; i++) begin
      if (w_load_hit[i]) begin
        r_entries[i].pc           <= alloc.pc;
        r_entries[i].grp_id       <= alloc.grp_id;
        // lanes that fault at dispatch are already finished
        r_entries[i].done_grp_id  <= alloc.except_valid;
        r_entries[i].dead         <= '0;
        r_entries[i].except_valid <= alloc.except_valid;
        r_entries[i].except_type  <= alloc.except_type;
      end else begin
        if (w_done_hit[i]) begin
          r_entries[i].done_grp_id <= r_entries[i].done_grp_id | i_done_lane;
          if (i_done_except_valid) begin
            r_entries[i].except_valid <= r_entries[i].except_valid | i_done_lane;
            for (int d = 0; d < `ROB_DISP_SIZE; d++) begin
              if (i_done_lane[d]) begin
                r_entries[i].except_type[d] <= i_done_except_type;
              end
            end
          end
        end
        // flush kills every group still in flight
        if (head.kill && r_valid[i]) begin
          r_entries[i].dead <= r_entries[i].grp_id;
        end
      end
    end
  end

  // head record, valid taken from the flag vector
  always_comb begin
    head.head_entry       = r_entries[head.head_idx];
    head.head_entry.valid = r_valid[head.head_idx];
  end

  // late reports from flushed groups may arrive while killing
  ap_done_target: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (i_done_valid && head.state == commit_normal) |->
      r_valid[w_done_idx] && $onehot(i_done_lane) &&
      ((i_done_lane & ~r_entries[w_done_idx].grp_id) == '0)
  );

endmodule

// File: src/rob_dispatch_intake.sv
`timescale 1ns/10ps
`include "rob_settings.svh"

module rob_dispatch_intake
  import rob_entry_pkg::*;
  import rob_except_pkg::*;
(
  input  logic                         i_clk,
  input  logic                         i_reset_n,

  input  logic                         i_disp_valid,
  input  grp_mask_t                    i_disp_grp_id,
  input  logic [`ROB_PC_W-1:0]         i_disp_pc,
  input  grp_mask_t                    i_disp_except_valid,
  input  except_t [`ROB_DISP_SIZE-1:0] i_disp_except_type,

  input  logic                         i_commit,
  input  logic                         i_flush,

  output cmt_id_t                      o_new_cmt_id,
  output logic [1:0]                   o_credit_return_val,

  rob_alloc_if.source                  alloc
);

  cmt_id_t r_alloc_id;
  logic    w_accept;
  logic    w_drop;

  // a group arriving with the flush belongs to the killed path
  assign w_accept = i_disp_valid & ~i_flush;
  assign w_drop   = i_disp_valid & i_flush;

  // ----------------------------------------
  // allocation pointer
  // ----------------------------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_alloc_id <= '0;
    end else if (w_accept) begin
      r_alloc_id <= r_alloc_id + 1'b1;
    end
  end

  assign o_new_cmt_id = r_alloc_id;

  // new group toward the entry array
  assign alloc.load_valid   = w_accept;
  assign alloc.load_idx     = r_alloc_id[ENTRY_W-1:0];
  assign alloc.grp_id       = i_disp_grp_id;
  assign alloc.pc           = i_disp_pc;
  assign alloc.except_valid = i_disp_except_valid & i_disp_grp_id;
  assign alloc.except_type  = i_disp_except_type;

  // ----------------------------------------
  // credit return
  // ----------------------------------------

  // one for the committed group, one more for a dropped dispatch
  assign o_credit_return_val = {1'b0, i_commit} + {1'b0, w_drop};

  // every dispatched group carries at least one lane
  ap_disp_not_empty: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid |-> (i_disp_grp_id != '0)
  );

endmodule

// File: src/rob_head_if.sv
`timescale 1ns/10ps
`include "rob_settings.svh"

interface rob_head_if
  import rob_entry_pkg::*;
  import rob_except_pkg::*;
();

  // record at the commit pointer
  rob_entry_t    head_entry;
  entry_idx_t    head_idx;

  // clears the head entry
  logic          commit_finish;

  // marks every valid entry dead
  logic          kill;

  // current commit state of the selector
  commit_state_t state;

  modport array (
    output head_entry,
    input  head_idx, commit_finish, kill, state
  );

  modport selector (
    input  head_entry,
    output head_idx, commit_finish, kill, state
  );

endinterface

// File: src/rob_alloc_if.sv
`timescale 1ns/10ps
`include "rob_settings.svh"

interface rob_alloc_if
  import rob_entry_pkg::*;
  import rob_except_pkg::*;
();

  // one-cycle write strobe for the entry at load_idx
  logic                         load_valid;
  entry_idx_t                   load_idx;

  // group contents
  grp_mask_t                    grp_id;
  logic [`ROB_PC_W-1:0]         pc;
  grp_mask_t                    except_valid;
  except_t [`ROB_DISP_SIZE-1:0] except_type;

  modport source (
    output load_valid, load_idx, grp_id, pc, except_valid, except_type
  );

  modport sink (
    input load_valid, load_idx, grp_id, pc, except_valid, except_type
  );

endinterface

// File: src/rob_entry_pkg.sv
`include "rob_settings.svh"

package rob_entry_pkg;
  import rob_except_pkg::*;

  // ----------------------------------------
  // indices
  // ----------------------------------------

  localparam int ENTRY_W = $clog2(`ROB_ENTRY_SIZE);

  // entry index alone
  typedef logic [ENTRY_W-1:0] entry_idx_t;

  // entry index plus the wrap bit
  typedef logic [ENTRY_W:0] cmt_id_t;

  // one bit per lane of a group
  typedef logic [`ROB_DISP_SIZE-1:0] grp_mask_t;

  // ----------------------------------------
  // stored record of one group
  // ----------------------------------------

  typedef struct packed {
    logic                         valid;
    logic [`ROB_PC_W-1:0]         pc;
    grp_mask_t                    grp_id;
    grp_mask_t                    done_grp_id;
    grp_mask_t                    dead;
    grp_mask_t                    except_valid;
    except_t [`ROB_DISP_SIZE-1:0] except_type;
  } rob_entry_t;

endpackage

// File: src/rob_except_pkg.sv
`include "rob_settings.svh"

package rob_except_pkg;

  // ----------------------------------------
  // exception causes
  // ----------------------------------------

  // values follow the machine cause codes
  typedef enum logic [`ROB_EXC_W-1:0] {
    inst_addr_misalign = 0,
    inst_acc_fault     = 1,
    illegal_inst       = 2,
    breakpoint         = 3,
    load_acc_fault     = 5,
    store_acc_fault    = 7,
    ecall_m            = 11
  } except_t;

  // ----------------------------------------
  // commit state
  // ----------------------------------------

  // killing drains the groups behind a committed exception
  typedef enum logic {
    commit_normal,
    commit_killing
  } commit_state_t;

endpackage

// File: src/rob_settings.svh
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// ----------------------------------------
// reorder buffer sizing
// ----------------------------------------

// lanes in one dispatch group
`define ROB_DISP_SIZE  4

// groups held in flight
`define ROB_ENTRY_SIZE 8

// widths of the pc and the exception cause
`define ROB_PC_W       32
`define ROB_EXC_W      4

`endif
